//--- design/cachePkg.sv
`default_nettype none

package cachePkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// cache geometry.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int ADDRESS_WIDTH = 8;
	localparam int DATA_WIDTH    = 32;
	localparam int SET_COUNT     = 4;
	localparam int WAY_COUNT     = 2;
	localparam int INDEX_WIDTH   = $clog2(SET_COUNT);
	localparam int TAG_WIDTH     = ADDRESS_WIDTH - INDEX_WIDTH;
	localparam int WAY_WIDTH     = $clog2(WAY_COUNT);

	// one word per line, so the address is just tag and index.
	typedef logic [ADDRESS_WIDTH-1:0] addressT;
	typedef logic [TAG_WIDTH-1:0]     tagT;     // upper address bits.
	typedef logic [INDEX_WIDTH-1:0]   indexT;   // lower address bits.
	typedef logic [DATA_WIDTH-1:0]    dataT;
	typedef logic [WAY_WIDTH-1:0]     wayT;

	// line states without any coherence traffic.
	typedef enum logic [1:0] {
		INVALID,
		CLEAN,
		MODIFIED
	} lineStateT;

endpackage : cachePkg

`default_nettype wire

//--- design/busPkg.sv
`default_nettype none

package busPkg;

	import cachePkg::*;

	localparam int QUEUE_DEPTH    = 4;  // also the number of credits.
	localparam int MEMORY_LATENCY = 3;
	localparam int MEMORY_WORDS   = 2 ** ADDRESS_WIDTH;
	localparam int POINTER_WIDTH  = $clog2(QUEUE_DEPTH);

	typedef logic [POINTER_WIDTH-1:0] queuePointerT;
	typedef logic [POINTER_WIDTH:0]   queueCountT;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic    write;
		addressT address;
		dataT    data;
	} cpuRequestT;

	typedef struct packed {
		logic    hit;
		logic    write;
		addressT address;
		dataT    data;
	} cpuResponseT;

	typedef struct packed {
		logic    write;
		addressT address;
		dataT    data;
	} memRequestT;

endpackage : busPkg

`default_nettype wire

//--- design/requestQueue.sv
`timescale 1ns/100ps
`default_nettype none

module requestQueue import busPkg::*; (
	input  logic       clock,
	input  logic       arstN,
	input  logic       cpuRequestValid,
	input  cpuRequestT cpuRequest,
	input  logic       queuePop,
	output logic       queueValid,
	output cpuRequestT queueHead,
	output logic       creditReturn
);

	cpuRequestT   entries [QUEUE_DEPTH];
	queuePointerT writePointer;
	queuePointerT readPointer;
	queueCountT   occupancy;

	// the producer only sends while it holds a credit, so a push never finds the buffer full.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			writePointer <= '0;
			readPointer  <= '0;
			occupancy    <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (cpuRequestValid)
				writePointer <= writePointer + 1'b1;
			if (queuePop)
				readPointer <= readPointer + 1'b1;
			case ({cpuRequestValid, queuePop})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
			creditReturn <= queuePop; // one credit back per entry that left.
		end
	end

	always_ff @(posedge clock) begin
		if (cpuRequestValid)
			entries[writePointer] <= cpuRequest;
	end

	assign queueValid = occupancy != '0;
	assign queueHead  = entries[readPointer];

endmodule : requestQueue

`default_nettype wire

//--- design/cacheController.sv
`timescale 1ns/100ps
`default_nettype none

module cacheController import cachePkg::*, busPkg::*; (
	input  logic        clock,
	input  logic        arstN,
	input  logic        queueValid,
	input  cpuRequestT  queueHead,
	output logic        queuePop,
	output indexT       lookupIndex,
	output tagT         lookupTag,
	input  logic        hit,
	input  wayT         hitWay,
	input  wayT         victimWay,
	input  lineStateT   victimState,
	input  tagT         victimTag,
	input  dataT        readData,
	output logic        lineWrite,
	output wayT         writeWay,
	output lineStateT   writeState,
	output dataT        writeData,
	output logic        touch,
	output wayT         touchWay,
	output logic        memRequestValid,
	output memRequestT  memRequest,
	input  logic        memResponseValid,
	input  dataT        memResponseData,
	output logic        cpuResponseValid,
	output cpuResponseT cpuResponse
);

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL,
		RESPOND
	} controllerStateT;

	controllerStateT state;
	cpuRequestT      request;
	wayT             fillWay;

	assign queuePop         = state == IDLE && queueValid;
	assign lookupIndex      = request.address[INDEX_WIDTH-1:0];
	assign lookupTag        = request.address[ADDRESS_WIDTH-1:INDEX_WIDTH];
	assign cpuResponseValid = state == RESPOND;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line writes and LRU updates.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		lineWrite  = 1'b0;
		writeWay   = fillWay;
		writeState = MODIFIED;
		writeData  = request.data;
		touch      = 1'b0;
		touchWay   = fillWay;
		case (state)
			LOOKUP: if (hit) begin
				lineWrite = request.write; // a read hit only moves the LRU bit.
				writeWay  = hitWay;
				touch     = 1'b1;
				touchWay  = hitWay;
			end
			REFILL: if (memResponseValid) begin
				lineWrite = 1'b1;
				touch     = 1'b1;
				if (!request.write) begin
					writeState = CLEAN;
					writeData  = memResponseData;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state           <= IDLE;
			memRequestValid <= 1'b0;
		end else begin
			memRequestValid <= 1'b0;
			case (state)
				IDLE: if (queueValid) state <= LOOKUP;
				LOOKUP: begin
					if (hit) begin
						state <= RESPOND;
					end else begin
						memRequestValid <= 1'b1;
						state <= victimState == MODIFIED ? WRITEBACK : REFILL;
					end
				end
				WRITEBACK: if (memResponseValid) begin
					memRequestValid <= 1'b1; // the refill read follows the write-back.
					state <= REFILL;
				end
				REFILL:  if (memResponseValid) state <= RESPOND;
				RESPOND: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (queuePop)
			request <= queueHead;
		case (state)
			LOOKUP: begin
				fillWay     <= victimWay;
				cpuResponse <= '{hit: hit, write: request.write, address: request.address,
					data: request.write ? request.data : readData};
				if (victimState == MODIFIED)
					memRequest <= '{write: 1'b1, address: {victimTag, lookupIndex}, data: readData};
				else
					memRequest <= '{write: 1'b0, address: request.address, data: request.data};
			end
			WRITEBACK: if (memResponseValid)
				memRequest <= '{write: 1'b0, address: request.address, data: request.data};
			REFILL: if (memResponseValid)
				cpuResponse.data <= request.write ? request.data : memResponseData;
			default: ;
		endcase
	end

endmodule : cacheController

`default_nettype wire

//--- design/setAssociativeCacheUnit.sv
`timescale 1ns/100ps
`default_nettype none

module setAssociativeCacheUnit import cachePkg::*; (
	input  logic      clock,
	input  logic      arstN,
	input  indexT     lookupIndex,
	input  tagT       lookupTag,
	output logic      hit,
	output wayT       hitWay,
	output wayT       victimWay,
	output lineStateT victimState,
	output tagT       victimTag,
	output dataT      readData,
	input  logic      lineWrite,
	input  wayT       writeWay,
	input  lineStateT writeState,
	input  dataT      writeData,
	input  logic      touch,
	input  wayT       touchWay
);

	tagT       tags   [SET_COUNT][WAY_COUNT];
	lineStateT states [SET_COUNT][WAY_COUNT];
	dataT      lines  [SET_COUNT][WAY_COUNT];
	wayT       lru    [SET_COUNT]; // points at the least recently used way.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tag compare and victim choice.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		hit       = 1'b0;
		hitWay    = '0;
		victimWay = lru[lookupIndex];
		// walking down leaves the lowest invalid way as victim.
		for (int w = WAY_COUNT - 1; w >= 0; w--) begin
			if (states[lookupIndex][w] == INVALID)
				victimWay = wayT'(w);
		end
		for (int w = 0; w < WAY_COUNT; w++) begin
			if (states[lookupIndex][w] != INVALID && tags[lookupIndex][w] == lookupTag) begin
				hit    = 1'b1;
				hitWay = wayT'(w);
			end
		end
		victimState = states[lookupIndex][victimWay];
		victimTag   = tags[lookupIndex][victimWay];
		readData    = lines[lookupIndex][hit ? hitWay : victimWay];
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int s = 0; s < SET_COUNT; s++) begin
				lru[s] <= '0;
				for (int w = 0; w < WAY_COUNT; w++)
					states[s][w] <= INVALID;
			end
		end else begin
			if (lineWrite)
				states[lookupIndex][writeWay] <= writeState;
			if (touch)
				lru[lookupIndex] <= ~touchWay; // with two ways the other one becomes LRU.
		end
	end

	always_ff @(posedge clock) begin
		if (lineWrite) begin
			tags[lookupIndex][writeWay]  <= lookupTag;
			lines[lookupIndex][writeWay] <= writeData;
		end
	end

endmodule : setAssociativeCacheUnit

`default_nettype wire

//--- design/mainMemory.sv
`timescale 1ns/100ps
`default_nettype none

module mainMemory import cachePkg::*, busPkg::*; (
	input  logic       clock,
	input  logic       arstN,
	input  logic       memRequestValid,
	input  memRequestT memRequest,
	output logic       memResponseValid,
	output dataT       memResponseData
);

	dataT                    storage  [MEMORY_WORDS];
	dataT                    dataLine [MEMORY_LATENCY];
	logic [MEMORY_LATENCY-1:0] validLine;
	dataT                    accessWord;

	// every word starts out holding its own address.
	initial begin
		for (int i = 0; i < MEMORY_WORDS; i++)
			storage[i] = dataT'(i);
	end

	assign accessWord = memRequest.write ? memRequest.data : storage[memRequest.address];

	always @(posedge clock) begin
		if (memRequestValid && memRequest.write)
			storage[memRequest.address] <= memRequest.data;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			validLine <= '0;
		else
			validLine <= {validLine[MEMORY_LATENCY-2:0], memRequestValid};
	end

	always_ff @(posedge clock) begin
		dataLine[0] <= accessWord;
		for (int i = 1; i < MEMORY_LATENCY; i++)
			dataLine[i] <= dataLine[i-1];
	end

	assign memResponseValid = validLine[MEMORY_LATENCY-1];
	assign memResponseData  = dataLine[MEMORY_LATENCY-1];

endmodule : mainMemory

`default_nettype wire

//--- design/cacheSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module cacheSubsystem import cachePkg::*, busPkg::*; (
	input  logic        clock,
	input  logic        arstN,
	input  logic        cpuRequestValid,
	input  cpuRequestT  cpuRequest,
	output logic        creditReturn,
	output logic        cpuResponseValid,
	output cpuResponseT cpuResponse
);

	logic       queueValid, queuePop;
	cpuRequestT queueHead;
	indexT      lookupIndex;
	tagT        lookupTag, victimTag;
	logic       hit, lineWrite, touch;
	wayT        hitWay, victimWay, writeWay, touchWay;
	lineStateT  victimState, writeState;
	dataT       readData, writeData, memResponseData;
	logic       memRequestValid, memResponseValid;
	memRequestT memRequest;

	requestQueue requestQueue(
		.clock(clock), .arstN(arstN),
		.cpuRequestValid(cpuRequestValid), .cpuRequest(cpuRequest),
		.queuePop(queuePop), .queueValid(queueValid), .queueHead(queueHead),
		.creditReturn(creditReturn)
	);

	cacheController cacheController(
		.clock(clock), .arstN(arstN),
		.queueValid(queueValid), .queueHead(queueHead), .queuePop(queuePop),
		.lookupIndex(lookupIndex), .lookupTag(lookupTag),
		.hit(hit), .hitWay(hitWay), .victimWay(victimWay), .victimState(victimState),
		.victimTag(victimTag), .readData(readData),
		.lineWrite(lineWrite), .writeWay(writeWay), .writeState(writeState),
		.writeData(writeData), .touch(touch), .touchWay(touchWay),
		.memRequestValid(memRequestValid), .memRequest(memRequest),
		.memResponseValid(memResponseValid), .memResponseData(memResponseData),
		.cpuResponseValid(cpuResponseValid), .cpuResponse(cpuResponse)
	);

	setAssociativeCacheUnit setAssociativeCacheUnit(
		.clock(clock), .arstN(arstN),
		.lookupIndex(lookupIndex), .lookupTag(lookupTag),
		.hit(hit), .hitWay(hitWay), .victimWay(victimWay), .victimState(victimState),
		.victimTag(victimTag), .readData(readData),
		.lineWrite(lineWrite), .writeWay(writeWay), .writeState(writeState),
		.writeData(writeData), .touch(touch), .touchWay(touchWay)
	);

	mainMemory mainMemory(
		.clock(clock), .arstN(arstN),
		.memRequestValid(memRequestValid), .memRequest(memRequest),
		.memResponseValid(memResponseValid), .memResponseData(memResponseData)
	);

endmodule : cacheSubsystem

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic clock,
	output logic arstN
);

	localparam realtime HALF_PERIOD = 4.0;
	localparam int      RESET_CYCLES = 5;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// release lands on a falling edge, away from the registers' active edge.
	initial begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		arstN = 1'b1;
	end

endmodule : clockGen

`default_nettype wire

//--- test/cacheSubsystem_assert.sv
`timescale 1ns/100ps
`default_nettype none

module cacheSubsystemAssert import busPkg::*; (
	input logic clock,
	input logic arstN,
	input logic cpuRequestValid,
	input logic queuePop,
	input logic creditReturn,
	input logic memRequestValid,
	input logic memResponseValid
);

	int pending; // entries pushed and not yet popped.

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			pending <= 0;
		else
			pending <= pending + int'(cpuRequestValid) - int'(queuePop);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	creditFromPop: assert property (@(posedge clock) disable iff (!arstN)
		creditReturn |-> $past(pending) > 0)
		else $error("credit returned while the queue was empty");

	queueBounded: assert property (@(posedge clock) disable iff (!arstN)
		pending <= QUEUE_DEPTH)
		else $error("queue holds more entries than it has credits");

	// one request at a time, and its answer after the fixed latency.
	memoryAnswers: assert property (@(posedge clock) disable iff (!arstN)
		memRequestValid |=> (!memRequestValid) [*MEMORY_LATENCY-1]
			##1 (memResponseValid && !memRequestValid))
		else $error("memory request overlapped or its response missed the fixed latency");

endmodule : cacheSubsystemAssert

bind cacheSubsystem cacheSubsystemAssert assertions (
	.clock(clock),
	.arstN(arstN),
	.cpuRequestValid(cpuRequestValid),
	.queuePop(queuePop),
	.creditReturn(creditReturn),
	.memRequestValid(memRequestValid),
	.memResponseValid(memResponseValid)
);

`default_nettype wire

//--- test/testBench.sv
`timescale 1ns/100ps
`default_nettype none

module testBench import cachePkg::*, busPkg::*; ();

	localparam int REQUEST_COUNT      = 300;
	localparam int CYCLES_PER_REQUEST = 40;
	localparam int TIMEOUT_CYCLES     = CYCLES_PER_REQUEST * REQUEST_COUNT;
	localparam int DRAIN_CYCLES       = 10;
	localparam int ADDRESS_BITS_USED  = 4; // 16 words, so sets conflict often.

	logic        clock;
	logic        arstN;
	logic        cpuRequestValid;
	cpuRequestT  cpuRequest;
	logic        creditReturn;
	logic        cpuResponseValid;
	cpuResponseT cpuResponse;

	logic [15:0] lfsr;
	int          credits;
	int          issued;
	int          received;
	int          cycleCount;
	int          errorCount;
	int          failureCount;
	cpuResponseT expectedQueue [$];

	// reference model of memory contents and cache directory.
	dataT      modelMemory [MEMORY_WORDS];
	tagT       tagCopy     [SET_COUNT][WAY_COUNT];
	lineStateT stateCopy   [SET_COUNT][WAY_COUNT];
	wayT       lruCopy     [SET_COUNT];

	clockGen clockGen (.clock(clock), .arstN(arstN));

	cacheSubsystem UUT (
		.clock(clock), .arstN(arstN),
		.cpuRequestValid(cpuRequestValid), .cpuRequest(cpuRequest),
		.creditReturn(creditReturn),
		.cpuResponseValid(cpuResponseValid), .cpuResponse(cpuResponse)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus source.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [15:0] stepLfsr(input logic [15:0] value);
		logic feedback;
		feedback = value[15] ^ value[13] ^ value[12] ^ value[10]; // x^16+x^14+x^13+x^11+1.
		return {value[14:0], feedback};
	endfunction

	task automatic drawBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = stepLfsr(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errorCount++;
		$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// model, updated when a request is issued.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic predictResponse(input cpuRequestT request, output cpuResponseT expected);
		indexT index;
		tagT   tag;
		wayT   way;
		logic  found;
		logic  placed;
		index  = request.address[INDEX_WIDTH-1:0];
		tag    = request.address[ADDRESS_WIDTH-1:INDEX_WIDTH];
		found  = 1'b0;
		placed = 1'b0;
		way    = '0;
		for (int w = 0; w < WAY_COUNT; w++) begin
			if (stateCopy[index][w] != INVALID && tagCopy[index][w] == tag) begin
				found = 1'b1;
				way   = wayT'(w);
			end
		end
		if (found) begin
			if (request.write)
				stateCopy[index][way] = MODIFIED;
		end else begin
			for (int w = 0; w < WAY_COUNT; w++) begin
				if (!placed && stateCopy[index][w] == INVALID) begin
					way    = wayT'(w);
					placed = 1'b1;
				end
			end
			if (!placed)
				way = lruCopy[index];
			tagCopy[index][way]   = tag;
			stateCopy[index][way] = request.write ? MODIFIED : CLEAN;
		end
		lruCopy[index] = (way == 0) ? wayT'(1) : wayT'(0); // the other way is now oldest.
		if (request.write)
			modelMemory[request.address] = request.data;
		expected.hit     = found;
		expected.write   = request.write;
		expected.address = request.address;
		expected.data    = modelMemory[request.address];
	endtask

	task automatic checkResponse();
		cpuResponseT expected;
		if (cpuResponseValid) begin
			if (expectedQueue.size() == 0) begin
				failureCount++;
				$display("at %0t ns a response arrived with no request outstanding", $time);
			end else begin
				expected = expectedQueue.pop_front();
				received++;
				if (cpuResponse.hit !== expected.hit)
					reportMismatch("cpuResponse.hit", expected.hit, cpuResponse.hit);
				if (cpuResponse.write !== expected.write)
					reportMismatch("cpuResponse.write", expected.write, cpuResponse.write);
				if (cpuResponse.address !== expected.address)
					reportMismatch("cpuResponse.address", expected.address, cpuResponse.address);
				if (cpuResponse.data !== expected.data)
					reportMismatch("cpuResponse.data", expected.data, cpuResponse.data);
			end
		end
	endtask

	task automatic collectCredit();
		if (creditReturn)
			credits++;
		if (credits > QUEUE_DEPTH || credits < 0) begin
			failureCount++;
			$display("at %0t ns the credit count left its range: %0d", $time, credits);
		end
	endtask

	task automatic driveRequest();
		logic [31:0] bits;
		cpuRequestT  request;
		cpuResponseT expected;
		cpuRequestValid = 1'b0;
		if (issued < REQUEST_COUNT && credits > 0) begin
			drawBits(2, bits);
			if (bits[1:0] != 2'b00) begin // issue in three cycles out of four.
				drawBits(1, bits);
				request.write = bits[0];
				drawBits(ADDRESS_BITS_USED, bits);
				request.address = addressT'(bits[ADDRESS_BITS_USED-1:0]);
				request.data    = '0;
				if (request.write) begin
					drawBits(DATA_WIDTH, bits);
					request.data = bits;
				end
				predictResponse(request, expected);
				expectedQueue.push_back(expected);
				cpuRequest      = request;
				cpuRequestValid = 1'b1;
				credits--;
				issued++;
			end
		end
	endtask

	initial begin
		cpuRequestValid = 1'b0;
		cpuRequest      = '0;
		lfsr            = 16'd27;
		credits         = QUEUE_DEPTH;
		issued          = 0;
		received        = 0;
		cycleCount      = 0;
		errorCount      = 0;
		failureCount    = 0;
		for (int i = 0; i < MEMORY_WORDS; i++)
			modelMemory[i] = dataT'(i);
		for (int s = 0; s < SET_COUNT; s++) begin
			lruCopy[s] = '0;
			for (int w = 0; w < WAY_COUNT; w++) begin
				tagCopy[s][w]   = '0;
				stateCopy[s][w] = INVALID;
			end
		end
		@(posedge arstN);
		while (!(issued == REQUEST_COUNT && received == REQUEST_COUNT)
			&& cycleCount < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycleCount++;
			checkResponse();
			collectCredit();
			driveRequest();
		end
		if (received != REQUEST_COUNT) begin
			failureCount++;
			$display("run did not complete: %0d of %0d responses after %0d cycles",
				received, REQUEST_COUNT, cycleCount);
		end else begin
			// extra responses or late credits would show up here.
			repeat (DRAIN_CYCLES) begin
				@(negedge clock);
				cpuRequestValid = 1'b0;
				checkResponse();
				collectCredit();
			end
			if (credits != QUEUE_DEPTH) begin
				failureCount++;
				$display("credits did not return to %0d, count is %0d", QUEUE_DEPTH, credits);
			end
		end
		$display("errors: %0d, failures: %0d", errorCount, failureCount);
		if (errorCount == 0 && failureCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule : testBench

`default_nettype wire

//--- vlog.f
design/cachePkg.sv
design/busPkg.sv
design/requestQueue.sv
design/cacheController.sv
design/setAssociativeCacheUnit.sv
design/mainMemory.sv
design/cacheSubsystem.sv
test/clockGen.sv
test/cacheSubsystem_assert.sv
test/testBench.sv

//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - files:
      - design/cachePkg.sv
      - design/busPkg.sv
      - design/requestQueue.sv
      - design/cacheController.sv
      - design/setAssociativeCacheUnit.sv
      - design/mainMemory.sv
      - design/cacheSubsystem.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/cacheSubsystem_assert.sv
      - test/testBench.sv
